// ==== data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module data_mem (
    input  wire logic            clk_i,
    input  wire sb_pkg::mem_wr_t wr_i,
    input  wire logic            we_i,
    input  wire sb_pkg::addr_t   rd_addr_i,
    output sb_pkg::word_t        rd_data_o
);

    localparam int IDX_W = $clog2(`SB_MEM_WORDS);

    sb_pkg::word_t    mem_q [`SB_MEM_WORDS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [1:0]       wr_lane;

    assign wr_idx  = wr_i.addr[IDX_W+1:2];  // word index, upper bits wrap
    assign rd_idx  = rd_addr_i[IDX_W+1:2];
    assign wr_lane = wr_i.addr[1:0];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            if (wr_i.is_byte) begin
                mem_q[wr_idx][8*wr_lane +: 8] <= wr_i.data[7:0];
            end else begin
                mem_q[wr_idx] <= wr_i.data;
            end
        end
    end

    // read returns the word as it was before a write at the same edge
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem_q[rd_idx];
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
sb_pkg.sv
store_buffer.sv
data_mem.sv
load_unit.sv
mem_subsystem.sv
sb_asserts.sv
tb_mem_subsystem.sv

// ==== load_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_unit (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire sb_pkg::load_req_t load_i,
    input  wire logic              load_valid_i,
    input  wire sb_pkg::fwd_t      fwd_i,
    input  wire sb_pkg::word_t     mem_rd_data_i,
    output sb_pkg::load_req_t      lookup_o,
    output logic                   lookup_valid_o,
    output sb_pkg::addr_t          mem_rd_addr_o,
    output logic                   port_free_o,
    output logic                   load_done_o,
    output sb_pkg::word_t          load_data_o,
    output logic                   load_busy_o
);

    sb_pkg::load_state_t state_q;
    sb_pkg::load_state_t state_n;
    sb_pkg::load_req_t   req_q;
    logic                rsp_q;     // fwd and memory data answer the last LOOKUP
    sb_pkg::word_t       src_word;
    logic [7:0]          lane_byte;

    always_comb begin
        state_n = state_q;
        unique case (state_q)
            sb_pkg::IDLE: begin
                if (load_valid_i) begin
                    state_n = sb_pkg::LOOKUP;
                end
            end
            sb_pkg::LOOKUP: begin
                state_n = sb_pkg::WAIT_DRAIN;
            end
            sb_pkg::WAIT_DRAIN: begin
                // first cycle finishes the load, later cycles poll until no overlap
                if (!fwd_i.conflict) begin
                    state_n = rsp_q ? sb_pkg::IDLE : sb_pkg::LOOKUP;
                end
            end
            default: begin
                state_n = sb_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= sb_pkg::IDLE;
            rsp_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            rsp_q   <= (state_q == sb_pkg::LOOKUP);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == sb_pkg::IDLE && load_valid_i) begin
            req_q <= load_i;
        end
    end

    assign lookup_o       = req_q;
    assign lookup_valid_o = (state_q != sb_pkg::IDLE);  // repeated while waiting
    assign mem_rd_addr_o  = req_q.addr;
    assign port_free_o    = (state_q != sb_pkg::LOOKUP);  // no drain under the read
    assign load_busy_o    = (state_q != sb_pkg::IDLE);

    assign load_done_o = (state_q == sb_pkg::WAIT_DRAIN) && rsp_q && !fwd_i.conflict;

    assign src_word    = fwd_i.hit ? fwd_i.data : mem_rd_data_i;
    assign lane_byte   = src_word[8*req_q.addr[1:0] +: 8];
    assign load_data_o = req_q.is_byte ? {{24{1'b0}}, lane_byte} : src_word;

endmodule

`default_nettype wire

// ==== mem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire sb_pkg::store_t    store_i,
    input  wire logic              store_valid_i,
    input  wire logic              kill_i,
    input  wire sb_pkg::pc_t       kill_pc_i,
    input  wire sb_pkg::load_req_t load_i,
    input  wire logic              load_valid_i,
    input  wire logic              drain_en_i,
    output logic                   full_o,
    output logic                   load_done_o,
    output sb_pkg::word_t          load_data_o,
    output logic                   load_busy_o
);

    sb_pkg::load_req_t lookup;
    logic              lookup_valid;
    sb_pkg::fwd_t      fwd;
    sb_pkg::mem_wr_t   mem_wr;
    logic              mem_we;
    sb_pkg::addr_t     mem_rd_addr;
    sb_pkg::word_t     mem_rd_data;
    logic              port_free;

    store_buffer store_buffer_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .st_i           (store_i),
        .st_valid_i     (store_valid_i),
        .kill_i         (kill_i),
        .kill_pc_i      (kill_pc_i),
        .lookup_i       (lookup),
        .lookup_valid_i (lookup_valid),
        .drain_en_i     (drain_en_i),
        .port_free_i    (port_free),
        .full_o         (full_o),
        .fwd_o          (fwd),
        .mem_wr_o       (mem_wr),
        .mem_we_o       (mem_we)
    );

    data_mem data_mem_i (
        .clk_i     (clk_i),
        .wr_i      (mem_wr),
        .we_i      (mem_we),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data)
    );

    load_unit load_unit_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .load_i         (load_i),
        .load_valid_i   (load_valid_i),
        .fwd_i          (fwd),
        .mem_rd_data_i  (mem_rd_data),
        .lookup_o       (lookup),
        .lookup_valid_o (lookup_valid),
        .mem_rd_addr_o  (mem_rd_addr),
        .port_free_o    (port_free),
        .load_done_o    (load_done_o),
        .load_data_o    (load_data_o),
        .load_busy_o    (load_busy_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_mem_subsystem -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== sb_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module sb_asserts #(
    parameter bit LOAD_SIDE = 1'b0
) (
    input wire logic                clk_i,
    input wire logic                rst_i,
    input wire logic                empty_i,
    input wire logic                full_i,
    input wire logic                mem_we_i,
    input wire logic                st_valid_i,
    input wire sb_pkg::load_state_t state_i,
    input wire logic                load_valid_i,
    input wire logic                port_free_i,
    input wire logic                load_done_i
);

    generate
        if (!LOAD_SIDE) begin : g_buf
            // an empty buffer with no incoming store has nothing to write next cycle
            a_no_drain_empty: assert property (@(posedge clk_i) disable iff (rst_i)
                (empty_i && !st_valid_i) |=> !mem_we_i)
                else $error("memory write while store buffer is empty");

            a_quiet_after_reset: assert property (@(posedge clk_i)
                $fell(rst_i) |-> (!full_i && !mem_we_i))
                else $error("full or memory write active right after reset");
        end else begin : g_load
            a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
                load_done_i |=> !load_done_i)
                else $error("load done held longer than one cycle");

            // accepted load enters LOOKUP and holds the port
            a_port_busy: assert property (@(posedge clk_i) disable iff (rst_i)
                (state_i == sb_pkg::IDLE && load_valid_i) |=> !port_free_i)
                else $error("memory port free during lookup");
        end
    endgenerate

endmodule

bind store_buffer sb_asserts #(.LOAD_SIDE(1'b0)) sb_asserts_buf_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .empty_i      (empty),
    .full_i       (full_o),
    .mem_we_i     (mem_we_o),
    .st_valid_i   (st_valid_i),
    .state_i      (sb_pkg::IDLE),
    .load_valid_i (1'b0),
    .port_free_i  (1'b1),
    .load_done_i  (1'b0)
);

bind load_unit sb_asserts #(.LOAD_SIDE(1'b1)) sb_asserts_load_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .empty_i      (1'b0),
    .full_i       (1'b0),
    .mem_we_i     (1'b0),
    .st_valid_i   (1'b0),
    .state_i      (state_q),
    .load_valid_i (load_valid_i),
    .port_free_i  (port_free_o),
    .load_done_i  (load_done_o)
);

`default_nettype wire

// ==== sb_params.svh ====
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// store buffer depth in entries
`define SB_DEPTH 8

// data memory depth in 32-bit words
`define SB_MEM_WORDS 256

// byte address width of loads, stores and the memory port
`define SB_ADDR_W 20

`endif

// ==== sb_pkg.sv ====
`default_nettype none

`include "sb_params.svh"

package sb_pkg;

    typedef logic [`SB_ADDR_W-1:0]       addr_t;   // byte address
    typedef logic [31:0]                 word_t;
    typedef logic [31:0]                 pc_t;     // store tag used by kill
    typedef logic [$clog2(`SB_DEPTH):0]  count_t;  // 0 .. SB_DEPTH

    // one buffered store, also the store input of the subsystem
    typedef struct packed {
        addr_t addr;
        word_t data;     // byte stores carry the byte in data[7:0]
        pc_t   pc;
        logic  is_byte;
    } store_t;

    // head of the buffer on its way to memory
    typedef struct packed {
        addr_t addr;
        word_t data;
        logic  is_byte;
    } mem_wr_t;

    typedef struct packed {
        addr_t addr;
        logic  is_byte;
    } load_req_t;

    // registered answer of the buffer lookup
    typedef struct packed {
        logic  hit;
        logic  conflict;  // overlapping store that cannot be forwarded
        word_t data;      // lane-aligned, load unit picks its byte
    } fwd_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WAIT_DRAIN
    } load_state_t;

endpackage

`default_nettype wire

// ==== store_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module store_buffer (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire sb_pkg::store_t    st_i,
    input  wire logic              st_valid_i,
    input  wire logic              kill_i,
    input  wire sb_pkg::pc_t       kill_pc_i,
    input  wire sb_pkg::load_req_t lookup_i,
    input  wire logic              lookup_valid_i,
    input  wire logic              drain_en_i,
    input  wire logic              port_free_i,
    output logic                   full_o,
    output sb_pkg::fwd_t           fwd_o,
    output sb_pkg::mem_wr_t        mem_wr_o,
    output logic                   mem_we_o
);

    localparam int IDX_W = $clog2(`SB_DEPTH);

    sb_pkg::store_t ent_q [`SB_DEPTH];  // index 0 is the oldest store
    sb_pkg::store_t ent_n [`SB_DEPTH];
    sb_pkg::count_t cnt_q;
    sb_pkg::count_t cnt_n;
    sb_pkg::fwd_t   fwd_q;
    sb_pkg::fwd_t   fwd_n;
    logic           empty;
    logic           drain;
    logic           accept;

    assign empty  = (cnt_q == '0);
    assign full_o = (cnt_q == sb_pkg::count_t'(`SB_DEPTH));
    assign drain  = drain_en_i && port_free_i && !empty;
    assign accept = st_valid_i && !full_o;  // no room taken from a same-cycle drain

    assign mem_we_o = drain;
    assign mem_wr_o = '{addr: ent_q[0].addr, data: ent_q[0].data, is_byte: ent_q[0].is_byte};

    // drain the head, then compact out killed entries, then append
    always_comb begin
        sb_pkg::store_t shifted [`SB_DEPTH];
        sb_pkg::count_t n_live;
        sb_pkg::count_t k;

        for (int i = 0; i < `SB_DEPTH - 1; i++) begin
            shifted[i] = drain ? ent_q[i+1] : ent_q[i];
        end
        shifted[`SB_DEPTH-1] = ent_q[`SB_DEPTH-1];
        n_live = cnt_q - sb_pkg::count_t'(drain);

        for (int i = 0; i < `SB_DEPTH; i++) begin
            ent_n[i] = shifted[i];
        end

        k = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (sb_pkg::count_t'(i) < n_live) begin
                if (!(kill_i && shifted[i].pc == kill_pc_i)) begin
                    ent_n[k[IDX_W-1:0]] = shifted[i];  // survivors keep their order
                    k = k + 1'b1;
                end
            end
        end

        if (accept) begin
            ent_n[k[IDX_W-1:0]] = st_i;
            k = k + 1'b1;
        end
        cnt_n = k;
    end

    // youngest store to the same word decides the answer
    always_comb begin
        fwd_n = '0;
        if (lookup_valid_i) begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                if (sb_pkg::count_t'(i) < cnt_q &&
                    ent_q[i].addr[`SB_ADDR_W-1:2] == lookup_i.addr[`SB_ADDR_W-1:2]) begin
                    if (!ent_q[i].is_byte) begin
                        fwd_n.hit      = 1'b1;
                        fwd_n.conflict = 1'b0;
                        fwd_n.data     = ent_q[i].data;
                    end else if (lookup_i.is_byte && ent_q[i].addr == lookup_i.addr) begin
                        fwd_n.hit      = 1'b1;
                        fwd_n.conflict = 1'b0;
                        fwd_n.data     = {4{ent_q[i].data[7:0]}};  // byte in every lane
                    end else begin
                        fwd_n.hit      = 1'b0;
                        fwd_n.conflict = 1'b1;
                        fwd_n.data     = '0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            fwd_q <= '0;
        end else begin
            cnt_q <= cnt_n;
            fwd_q <= fwd_n;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            ent_q[i] <= ent_n[i];
        end
    end

    assign fwd_o = fwd_q;

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sb_params.svh"

module tb_mem_subsystem;

    logic              clk_i;
    logic              rst_i;
    sb_pkg::store_t    store_i;
    logic              store_valid_i;
    logic              kill_i;
    sb_pkg::pc_t       kill_pc_i;
    sb_pkg::load_req_t load_i;
    logic              load_valid_i;
    logic              drain_en_i;
    logic              full_o;
    logic              load_done_o;
    sb_pkg::word_t     load_data_o;
    logic              load_busy_o;

    integer seed = 64;
    int     value_errs = 0;
    int     other_errs = 0;
    int     cycles = 0;
    int     ops = 0;
    int     done_count = 0;

    // shadow state of buffer, memory and load FSM
    sb_pkg::store_t sq [$];
    sb_pkg::store_t kept [$];
    sb_pkg::word_t  smem [`SB_MEM_WORDS];
    int             lst = 0;          // 0 idle, 1 lookup, 2 first answer, 3 polling
    logic           cur_conf = 1'b0;  // conflict flag seen by the load unit this cycle
    sb_pkg::load_req_t lreq;
    sb_pkg::word_t  exp_data;
    sb_pkg::word_t  last_data;

    mem_subsystem mem_subsystem_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .store_i       (store_i),
        .store_valid_i (store_valid_i),
        .kill_i        (kill_i),
        .kill_pc_i     (kill_pc_i),
        .load_i        (load_i),
        .load_valid_i  (load_valid_i),
        .drain_en_i    (drain_en_i),
        .full_o        (full_o),
        .load_done_o   (load_done_o),
        .load_data_o   (load_data_o),
        .load_busy_o   (load_busy_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    function automatic sb_pkg::word_t fill_word(input sb_pkg::addr_t a);
        return {12'hC3A, a};
    endfunction

    // expected load result where the youngest store to the same word decides
    function automatic sb_pkg::word_t ref_load(input sb_pkg::load_req_t req,
                                               output logic conflict);
        sb_pkg::word_t w;
        logic          found;
        int            lane;
        conflict = 1'b0;
        found    = 1'b0;
        lane     = int'(req.addr[1:0]);
        w        = smem[req.addr[9:2]];
        for (int i = sq.size() - 1; i >= 0 && !found; i--) begin
            if (sq[i].addr[`SB_ADDR_W-1:2] == req.addr[`SB_ADDR_W-1:2]) begin
                found = 1'b1;
                if (!sq[i].is_byte) begin
                    w = sq[i].data;
                end else if (req.is_byte && sq[i].addr == req.addr) begin
                    w[8*lane +: 8] = sq[i].data[7:0];
                end else begin
                    conflict = 1'b1;
                end
            end
        end
        if (req.is_byte) begin
            return {24'h0, w[8*lane +: 8]};
        end
        return w;
    endfunction

    task automatic check_word(input string name, input sb_pkg::word_t exp,
                              input sb_pkg::word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // reference model and compare step at every rising edge
    always @(posedge clk_i) begin
        logic          conf;
        logic          drain;
        logic          done_exp;
        sb_pkg::word_t w;
        sb_pkg::store_t head;
        if (rst_i) begin
            sq.delete();
            lst      = 0;
            cur_conf = 1'b0;
        end else if (cycles >= 20 * ops + 200) begin
            other_errs++;
            $display("Timeout: the run hung after %0d cycles", cycles);
            $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cycles++;
            done_exp = (lst == 2) && !cur_conf;
            check_flag("full_o", sq.size() == `SB_DEPTH, full_o);
            check_flag("load_busy_o", lst != 0, load_busy_o);
            check_flag("load_done_o", done_exp, load_done_o);
            if (done_exp) begin
                check_word("load_data_o", exp_data, load_data_o);
                last_data = load_data_o;
                done_count++;
            end

            conf = 1'b0;
            if (lst != 0) begin
                w = ref_load(lreq, conf);
                if (lst == 1) begin
                    exp_data = w;
                end
            end

            drain = drain_en_i && (lst != 1) && (sq.size() > 0);
            if (drain) begin
                head = sq.pop_front();
                if (head.is_byte) begin
                    smem[head.addr[9:2]][8*head.addr[1:0] +: 8] = head.data[7:0];
                end else begin
                    smem[head.addr[9:2]] = head.data;
                end
            end
            if (kill_i) begin
                kept.delete();
                foreach (sq[i]) begin
                    if (sq[i].pc != kill_pc_i) begin
                        kept.push_back(sq[i]);
                    end
                end
                sq = kept;
            end
            if (store_valid_i && !full_o) begin
                sq.push_back(store_i);
            end

            case (lst)
                0: if (load_valid_i) begin
                    lreq = load_i;
                    lst  = 1;
                end
                1: lst = 2;
                2: lst = cur_conf ? 3 : 0;
                default: if (!cur_conf) lst = 1;
            endcase
            cur_conf = conf;
        end
    end

    task automatic push_store(input sb_pkg::addr_t a, input sb_pkg::word_t d,
                              input sb_pkg::pc_t pc, input logic b);
        @(negedge clk_i);
        store_i       = '{addr: a, data: d, pc: pc, is_byte: b};
        store_valid_i = 1'b1;
        ops++;
        @(negedge clk_i);
        store_valid_i = 1'b0;
    endtask

    task automatic kill_stores(input sb_pkg::pc_t pc);
        @(negedge clk_i);
        kill_i    = 1'b1;
        kill_pc_i = pc;
        ops++;
        @(negedge clk_i);
        kill_i = 1'b0;
    endtask

    task automatic run_load(input sb_pkg::addr_t a, input logic b,
                            output sb_pkg::word_t data);
        int start;
        @(negedge clk_i);
        while (load_busy_o) @(negedge clk_i);
        start        = done_count;
        load_i       = '{addr: a, is_byte: b};
        load_valid_i = 1'b1;
        ops += 2;
        @(negedge clk_i);
        load_valid_i = 1'b0;
        while (done_count == start) @(negedge clk_i);
        data = last_data;
    endtask

    task automatic drain_all();
        @(negedge clk_i);
        drain_en_i = 1'b1;
        ops += 8;
        while (sq.size() != 0 || load_busy_o) @(negedge clk_i);
    endtask

    initial begin
        sb_pkg::word_t d;
        sb_pkg::word_t exp;
        logic [31:0]   rnd;
        store_i       = '0;
        store_valid_i = 1'b0;
        kill_i        = 1'b0;
        kill_pc_i     = '0;
        load_i        = '0;
        load_valid_i  = 1'b0;
        drain_en_i    = 1'b0;
        rst_i         = 1'b1;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // known contents for words 0..63
        drain_en_i = 1'b1;
        for (int i = 0; i < 64; i++) begin
            push_store(sb_pkg::addr_t'(4 * i), fill_word(sb_pkg::addr_t'(4 * i)), 32'h0, 1'b0);
        end
        drain_all();

        // fill and full with stores 9 and 10 dropped
        drain_en_i = 1'b0;
        for (int i = 0; i < 10; i++) begin
            push_store(sb_pkg::addr_t'(32'hC0 + 4 * i), 32'h1000_0000 + i, 32'h10 + i, 1'b0);
        end
        check_flag("full_o", 1'b1, full_o);
        drain_all();
        for (int i = 0; i < 10; i++) begin
            run_load(sb_pkg::addr_t'(32'hC0 + 4 * i), 1'b0, d);
            exp = (i < 8) ? 32'h1000_0000 + i : fill_word(sb_pkg::addr_t'(32'hC0 + 4 * i));
            check_word("load_data_o", exp, d);
        end

        // forwarding from a word store and a byte store
        drain_en_i = 1'b0;
        push_store(20'h80, 32'h1122_3344, 32'h20, 1'b0);
        for (int l = 0; l < 4; l++) begin
            run_load(sb_pkg::addr_t'(32'h80 + l), 1'b1, d);
            check_word("load_data_o", 32'h1122_3344 >> (8 * l) & 32'hFF, d);
        end
        run_load(20'h80, 1'b0, d);
        check_word("load_data_o", 32'h1122_3344, d);
        push_store(20'h85, 32'h0000_005A, 32'h21, 1'b1);
        run_load(20'h85, 1'b1, d);
        check_word("load_data_o", 32'h5A, d);
        drain_all();

        // conflict wait until the byte store drains
        drain_en_i = 1'b0;
        push_store(20'h92, 32'h0000_00E7, 32'h30, 1'b1);
        @(negedge clk_i);
        load_i       = '{addr: 20'h90, is_byte: 1'b0};
        load_valid_i = 1'b1;
        ops += 2;
        @(negedge clk_i);
        load_valid_i = 1'b0;
        repeat (8) @(negedge clk_i);
        check_flag("load_busy_o", 1'b1, load_busy_o);
        drain_all();
        exp = fill_word(20'h90);
        exp[23:16] = 8'hE7;
        check_word("load_data_o", exp, last_data);

        // kill two stores by PC
        drain_en_i = 1'b0;
        push_store(20'hA0, 32'hAAAA_0001, 32'h41, 1'b0);
        push_store(20'hA4, 32'hAAAA_0002, 32'h42, 1'b0);
        push_store(20'hA0, 32'hAAAA_0003, 32'h43, 1'b0);
        push_store(20'hA8, 32'hAAAA_0004, 32'h44, 1'b0);
        kill_stores(32'h43);
        kill_stores(32'h42);
        drain_all();
        run_load(20'hA0, 1'b0, d);
        check_word("load_data_o", 32'hAAAA_0001, d);
        run_load(20'hA4, 1'b0, d);
        check_word("load_data_o", fill_word(20'hA4), d);
        run_load(20'hA8, 1'b0, d);
        check_word("load_data_o", 32'hAAAA_0004, d);
        drain_en_i = 1'b0;
        push_store(20'hA0, 32'hBBBB_0005, 32'h45, 1'b0);
        push_store(20'hA0, 32'hBBBB_0006, 32'h46, 1'b0);
        drain_all();
        run_load(20'hA0, 1'b0, d);
        check_word("load_data_o", 32'hBBBB_0006, d);

        // random mix over words 0..15
        repeat (300) begin
            @(negedge clk_i);
            rnd           = $random(seed);
            store_valid_i = (rnd[1:0] == 2'd0);
            store_i       = '{addr: sb_pkg::addr_t'(rnd[7:2]), data: $random(seed),
                              pc: sb_pkg::pc_t'(rnd[10:8]), is_byte: rnd[11]};
            kill_i        = (rnd[15:12] == 4'd0);
            kill_pc_i     = sb_pkg::pc_t'(rnd[18:16]);
            load_valid_i  = (rnd[20:19] == 2'd0);
            load_i        = '{addr: sb_pkg::addr_t'(rnd[26:21]), is_byte: rnd[27]};
            drain_en_i    = (rnd[29:28] != 2'd0);
            ops += 2;
        end
        @(negedge clk_i);
        store_valid_i = 1'b0;
        kill_i        = 1'b0;
        load_valid_i  = 1'b0;
        drain_all();

        $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
